/* run_sim.sh */
#!/usr/bin/env bash
# Build the linproj testbench with Verilator, run it and check the result line

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not installed or not on PATH"
    exit 1
fi

verilator --binary --timing -f verilog.f --top-module tb_linproj \
    -Mdir obj_dir -o sim_tb_linproj
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb_linproj 2>&1)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -Fqx "TEST RESULT: PASS"; then
    exit 0
fi
echo "Simulation output has no pass line"
exit 1

/* src/apb_front.sv */
// APB slave front end
`timescale 1ns/100ps
`default_nettype none

module apb_front (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire linproj_pkg::apb_addr_t paddr,
    input  wire linproj_pkg::apb_word_t pwdata,
    output linproj_pkg::apb_word_t      prdata,
    output logic                        pready,
    output logic                        pslverr,
    mat_wr_if.master                    wr,
    output logic                        host_sel,
    output linproj_pkg::a_addr_t        host_addr,
    input  wire linproj_pkg::blk_t      host_data,
    output logic                        start,
    input  wire logic                   busy,
    input  wire logic                   done,
    output linproj_pkg::res_addr_t      rd_idx,
    input  wire linproj_pkg::acc_t      rd_data
);
    import linproj_pkg::*;

    logic setup_ph;
    logic access_ph;
    logic is_ctrl;
    logic is_status;
    logic is_a;
    logic is_w;
    logic is_res;
    logic mapped;
    logic err_d;
    logic err_q;

    assign setup_ph  = psel & ~penable;
    assign access_ph = psel & penable;

    // Address decode, word aligned only
    assign is_ctrl   = (paddr == REG_CTRL);
    assign is_status = (paddr == REG_STATUS);
    assign is_a   = (paddr[1:0] == 2'b00) && (paddr >= A_BASE)
                 && (paddr < A_BASE + apb_addr_t'(4 * A_WORDS));
    assign is_w   = (paddr[1:0] == 2'b00) && (paddr >= W_BASE)
                 && (paddr < W_BASE + apb_addr_t'(4 * W_WORDS));
    assign is_res = (paddr[1:0] == 2'b00) && (paddr >= RES_BASE)
                 && (paddr < RES_BASE + apb_addr_t'(4 * RES_WORDS));
    assign mapped = is_ctrl | is_status | is_a | is_w | is_res;

    // Error cases, judged in the setup phase
    always_comb begin
        err_d = ~mapped;
        if (pwrite && (is_res || is_status))
            err_d = 1'b1;
        if (pwrite && busy && (is_a || is_w))
            err_d = 1'b1;
        // Start while a run is active
        if (pwrite && busy && is_ctrl && pwdata[0])
            err_d = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_q <= 1'b0;
            start <= 1'b0;
        end else begin
            if (setup_ph)
                err_q <= err_d;
            // Start pulse lands in the cycle after the CTRL access
            start <= access_ph & pwrite & ~err_q & is_ctrl & pwdata[0];
        end
    end

    // Store writes in the access cycle
    assign wr.wr_en   = access_ph & pwrite & ~err_q & (is_a | is_w);
    assign wr.wr_sel  = is_w;
    assign wr.wr_addr = paddr[5:2];
    assign wr.wr_data = pwdata[15:0];

    // Host read port sampled by the store during setup
    assign host_sel  = is_w;
    assign host_addr = paddr[5:2];
    assign rd_idx    = paddr[5:2];

    assign pready  = 1'b1;
    assign pslverr = access_ph & err_q;

    // Read data, zero on writes and errors
    always_comb begin
        prdata = '0;
        if (access_ph && !pwrite && !err_q) begin
            if (is_status)
                prdata = {30'b0, done, busy};
            else if (is_a || is_w)
                prdata = {16'b0, host_data};
            else if (is_res)
                prdata = rd_data;
        end
    end

endmodule

`default_nettype wire

/* src/block_mac.sv */
// Two-lane block multiply-accumulate
`timescale 1ns/100ps
`default_nettype none

module block_mac (
    input  wire logic clk,
    input  wire logic rst_n,
    mat_rd_if.mac     rd,
    res_if.master     res
);
    import linproj_pkg::*;

    acc_t acc0;
    acc_t acc1;
    acc_t sum0;
    acc_t sum1;
    acc_t next0;
    acc_t next1;

    // Signed dot product of one two-element block
    function automatic acc_t dot2(input blk_t x, input blk_t w);
        elem_t x0;
        elem_t x1;
        elem_t w0;
        elem_t w1;
        acc_t  p0;
        acc_t  p1;
        x0 = elem_t'(x[ELEM_W-1:0]);
        x1 = elem_t'(x[2*ELEM_W-1:ELEM_W]);
        w0 = elem_t'(w[ELEM_W-1:0]);
        w1 = elem_t'(w[2*ELEM_W-1:ELEM_W]);
        p0 = acc_t'(x0) * acc_t'(w0);
        p1 = acc_t'(x1) * acc_t'(w1);
        return p0 + p1;
    endfunction

    // Lane 0 even row, lane 1 odd row, same weight column
    assign sum0 = dot2(rd.data_a, rd.data_w);
    assign sum1 = dot2(rd.data_b, rd.data_w);

    // First block restarts the sum
    assign next0 = rd.blk_first ? sum0 : acc0 + sum0;
    assign next1 = rd.blk_first ? sum1 : acc1 + sum1;

    always_ff @(posedge clk) begin
        if (rd.blk_valid) begin
            acc0 <= next0;
            acc1 <= next1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            res.res_valid <= 1'b0;
        else
            res.res_valid <= rd.blk_valid & rd.blk_last;
    end

    // Results and coordinates held with the pulse
    always_ff @(posedge clk) begin
        if (rd.blk_valid && rd.blk_last) begin
            res.res_data0    <= next0;
            res.res_data1    <= next1;
            res.res_row_even <= rd.res_row;
            res.res_col      <= rd.res_col;
        end
    end

endmodule

`default_nettype wire

/* src/linproj_if.sv */
// Internal buses of the accelerator
`timescale 1ns/100ps
`default_nettype none

// Host writes into the matrix stores
interface mat_wr_if;
    import linproj_pkg::*;

    logic    wr_en;
    // 0 selects the input store, 1 the weight store
    logic    wr_sel;
    a_addr_t wr_addr;
    blk_t    wr_data;

    modport master (output wr_en, wr_sel, wr_addr, wr_data);
    modport slave  (input  wr_en, wr_sel, wr_addr, wr_data);
endinterface

// Block reads for a run, with sideband aligned to the read data
interface mat_rd_if;
    import linproj_pkg::*;

    logic      rd_en;
    a_addr_t   addr_a;
    a_addr_t   addr_b;
    w_addr_t   addr_w;
    blk_t      data_a;
    blk_t      data_b;
    blk_t      data_w;
    logic      blk_valid;
    logic      blk_first;
    logic      blk_last;
    pair_idx_t res_row;
    col_idx_t  res_col;

    modport seq   (output rd_en, addr_a, addr_b, addr_w,
                   output blk_valid, blk_first, blk_last, res_row, res_col);
    modport store (input rd_en, addr_a, addr_b, addr_w,
                   output data_a, data_b, data_w);
    modport mac   (input data_a, data_b, data_w,
                   input blk_valid, blk_first, blk_last, res_row, res_col);
endinterface

// Finished result pair for one column
interface res_if;
    import linproj_pkg::*;

    logic      res_valid;
    pair_idx_t res_row_even;
    col_idx_t  res_col;
    acc_t      res_data0;
    acc_t      res_data1;

    modport master (output res_valid, res_row_even, res_col, res_data0, res_data1);
    modport slave  (input  res_valid, res_row_even, res_col, res_data0, res_data1);
endinterface

`default_nettype wire

/* src/linproj_pkg.sv */
// Linear projection accelerator
// Shared sizes, types and register map
`default_nettype none

package linproj_pkg;

    // Matrix geometry
    localparam int ELEM_W    = 8;
    localparam int BLOCK     = 2;
    localparam int ROWS_A    = 4;
    localparam int INNER     = 8;
    localparam int COLS_W    = 4;
    localparam int KB        = INNER / BLOCK;
    localparam int ACC_W     = 32;
    localparam int A_WORDS   = ROWS_A * KB;
    localparam int W_WORDS   = COLS_W * KB;
    localparam int RES_WORDS = ROWS_A * COLS_W;

    // Two rows of A are processed together
    localparam int PAIRS      = ROWS_A / 2;
    localparam int RES_PULSES = PAIRS * COLS_W;

    // APB byte addresses
    localparam logic [11:0] REG_CTRL   = 12'h000;
    localparam logic [11:0] REG_STATUS = 12'h004;
    localparam logic [11:0] A_BASE     = 12'h100;
    localparam logic [11:0] W_BASE     = 12'h200;
    localparam logic [11:0] RES_BASE   = 12'h300;

    typedef logic signed [ELEM_W-1:0]       elem_t;
    typedef logic [BLOCK*ELEM_W-1:0]        blk_t;
    typedef logic signed [ACC_W-1:0]        acc_t;
    typedef logic [$clog2(A_WORDS)-1:0]     a_addr_t;
    typedef logic [$clog2(W_WORDS)-1:0]     w_addr_t;
    typedef logic [$clog2(RES_WORDS)-1:0]   res_addr_t;
    typedef logic [31:0]                    apb_word_t;
    typedef logic [11:0]                    apb_addr_t;

    // Loop indices of the sequencer
    typedef logic [$clog2(KB)-1:0]          blk_idx_t;
    typedef logic [$clog2(COLS_W)-1:0]      col_idx_t;
    typedef logic [$clog2(PAIRS)-1:0]       pair_idx_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DRAIN
    } seq_state_t;

endpackage

`default_nettype wire

/* src/linproj_top.sv */
// Linear projection accelerator top
`timescale 1ns/100ps
`default_nettype none

module linproj_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire linproj_pkg::apb_addr_t paddr,
    input  wire linproj_pkg::apb_word_t pwdata,
    output linproj_pkg::apb_word_t      prdata,
    output logic                        pready,
    output logic                        pslverr
);
    import linproj_pkg::*;

    mat_wr_if mat_wr ();
    mat_rd_if mat_rd ();
    res_if    res    ();

    // Host readback and control between the blocks
    logic      host_sel;
    a_addr_t   host_addr;
    blk_t      host_data;
    logic      start;
    logic      busy;
    logic      done;
    res_addr_t rd_idx;
    acc_t      rd_data;

    apb_front i_apb_front (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .wr        (mat_wr.master),
        .host_sel  (host_sel),
        .host_addr (host_addr),
        .host_data (host_data),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data)
    );

    mat_store i_mat_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (mat_wr.slave),
        .rd        (mat_rd.store),
        .host_sel  (host_sel),
        .host_addr (host_addr),
        .host_data (host_data)
    );

    proj_seq i_proj_seq (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .rd    (mat_rd.seq)
    );

    block_mac i_block_mac (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (mat_rd.mac),
        .res   (res.master)
    );

    result_buf i_result_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .res     (res.slave),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .busy    (busy),
        .done    (done)
    );

endmodule

`default_nettype wire

/* src/mat_store.sv */
// Input and weight block memories
`timescale 1ns/100ps
`default_nettype none

module mat_store (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    mat_wr_if.slave                   wr,
    mat_rd_if.store                   rd,
    input  wire logic                 host_sel,
    input  wire linproj_pkg::a_addr_t host_addr,
    output linproj_pkg::blk_t         host_data
);
    import linproj_pkg::*;

    blk_t in_mem [A_WORDS];
    blk_t w_mem  [W_WORDS];

    // Writes from the host, memories start cleared
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < A_WORDS; i++)
                in_mem[i] <= '0;
            for (int j = 0; j < W_WORDS; j++)
                w_mem[j] <= '0;
        end else if (wr.wr_en) begin
            if (wr.wr_sel)
                w_mem[wr.wr_addr] <= wr.wr_data;
            else
                in_mem[wr.wr_addr] <= wr.wr_data;
        end
    end

    // Run reads, port A even row and port B odd row
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd.data_a <= in_mem[rd.addr_a];
            rd.data_b <= in_mem[rd.addr_b];
            rd.data_w <= w_mem[rd.addr_w];
        end
    end

    // Host readback, one cycle
    always_ff @(posedge clk) begin
        host_data <= host_sel ? w_mem[host_addr] : in_mem[host_addr];
    end

endmodule

`default_nettype wire

/* src/proj_seq.sv */
// Run sequencer for block reads
`timescale 1ns/100ps
`default_nettype none

module proj_seq (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic start,
    mat_rd_if.seq     rd
);
    import linproj_pkg::*;

    seq_state_t state;
    blk_idx_t   blk_cnt;
    col_idx_t   col_cnt;
    pair_idx_t  pair_cnt;
    logic       blk_end;
    logic       col_end;
    logic       pair_end;
    logic       last_read;

    assign blk_end   = (blk_cnt == blk_idx_t'(KB - 1));
    assign col_end   = (col_cnt == col_idx_t'(COLS_W - 1));
    assign pair_end  = (pair_cnt == pair_idx_t'(PAIRS - 1));
    assign last_read = blk_end & col_end & pair_end;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= SEQ_IDLE;
            blk_cnt  <= '0;
            col_cnt  <= '0;
            pair_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start)
                        state <= SEQ_RUN;
                end
                SEQ_RUN: begin
                    // Block fastest, then column, then row pair
                    if (blk_end) begin
                        blk_cnt <= '0;
                        if (col_end) begin
                            col_cnt  <= '0;
                            pair_cnt <= pair_end ? '0 : pair_cnt + 1'b1;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end else begin
                        blk_cnt <= blk_cnt + 1'b1;
                    end
                    if (last_read)
                        state <= SEQ_DRAIN;
                end
                // Final block sits in the data stage
                SEQ_DRAIN: begin
                    state <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // One read per cycle while running
    assign rd.rd_en = (state == SEQ_RUN);

    // Even row, odd row below it, and the weight column
    assign rd.addr_a = a_addr_t'(2 * KB * pair_cnt + blk_cnt);
    assign rd.addr_b = a_addr_t'((2 * pair_cnt + 1) * KB + blk_cnt);
    assign rd.addr_w = w_addr_t'(col_cnt * KB + blk_cnt);

    // Sideband delayed to match the registered store reads
    always_ff @(posedge clk) begin
        if (!rst_n)
            rd.blk_valid <= 1'b0;
        else
            rd.blk_valid <= rd.rd_en;
    end

    always_ff @(posedge clk) begin
        rd.blk_first <= (blk_cnt == '0);
        rd.blk_last  <= blk_end;
        rd.res_row   <= pair_cnt;
        rd.res_col   <= col_cnt;
    end

endmodule

`default_nettype wire

/* src/result_buf.sv */
// Result memory and run status
`timescale 1ns/100ps
`default_nettype none

module result_buf (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start,
    res_if.slave                        res,
    input  wire linproj_pkg::res_addr_t rd_idx,
    output linproj_pkg::acc_t           rd_data,
    output logic                        busy,
    output logic                        done
);
    import linproj_pkg::*;

    acc_t                         res_mem [RES_WORDS];
    logic [$clog2(RES_PULSES):0]  res_cnt;
    res_addr_t                    idx_even;
    res_addr_t                    idx_odd;

    // Odd row sits one row below the even one
    assign idx_even = res_addr_t'(2 * COLS_W * res.res_row_even + res.res_col);
    assign idx_odd  = res_addr_t'((2 * res.res_row_even + 1) * COLS_W + res.res_col);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RES_WORDS; i++)
                res_mem[i] <= '0;
        end else if (res.res_valid) begin
            res_mem[idx_even] <= res.res_data0;
            res_mem[idx_odd]  <= res.res_data1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_cnt <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else if (start) begin
            // Old results remain until overwritten
            res_cnt <= '0;
            busy    <= 1'b1;
            done    <= 1'b0;
        end else if (res.res_valid) begin
            res_cnt <= res_cnt + 1'b1;
            if (res_cnt == ($clog2(RES_PULSES) + 1)'(RES_PULSES - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    assign rd_data = res_mem[rd_idx];

endmodule

`default_nettype wire

/* tests/linproj_patterns.txt */
// One 128-bit word per line: lines 0-3 rows of A, 4-7 columns of W, 8-11 rows of C
// A and W hold element k at bits 8k+7:8k, C holds column c at bits 32c+31:32c
// Rows of A
00000000000000000807060504030201
0000000000000000f8f9fafbfcfdfeff
00000000000000007f1eec0014f6000a
000000000000000009000105fd024080
// Columns of W
00000000000000000101010101010101
00000000000000000104fe010300ff02
000000000000000005fd020100007f80
0000000000000000ff01000028e2140a
// Rows of C, signed 32-bit
00000077000000a20000002900000024
ffffff89ffffff5effffffd7ffffffdc
0000044ffffffcf90000016f0000009d
ffffff4300005ff4fffffec3ffffffce

/* tests/tb_linproj.sv */
// Linear projection accelerator testbench
`timescale 1ns/100ps
`default_nettype none

module tb_linproj;
    import linproj_pkg::*;

    localparam int          CLK_PERIOD  = 20;
    localparam int          RST_CYCLES  = 8;
    localparam int          DRIVE_DLY   = 2;
    localparam int          APB_TIMEOUT = 16;
    localparam int          DONE_POLLS  = 40;
    localparam logic [15:0] LFSR_SEED   = 16'd37521;
    localparam logic [15:0] LFSR_TAPS   = 16'hB400;

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_word_t pwdata;
    apb_word_t prdata;
    logic      pready;
    logic      pslverr;

    // Pattern words and the matrices unpacked from them
    logic [127:0] pat_mem [12];
    elem_t        a_cur [ROWS_A][INNER];
    elem_t        w_cur [COLS_W][INNER];
    acc_t         c_exp [ROWS_A][COLS_W];
    logic [15:0]  lfsr_state;

    linproj_top i_linproj_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input apb_word_t got, input apb_word_t exp, input string msg);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0d ns: %s, got %h, expected %h",
                                $time, msg, got, exp));
    endtask

    // Galois step that shifts right and folds the taps in when a one drops out
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic next_rand_byte(output logic [7:0] b);
        b = '0;
        for (int n = 0; n < 8; n++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    // Setup cycle then access cycle sampled mid-cycle until pready
    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_word_t wdata, output apb_word_t data,
                                output logic err);
        int waits;
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready && waits < APB_TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (!pready)
            abort_run($sformatf("APB transfer to address %h never saw pready", addr));
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Writes always return zero read data
    task automatic apb_write(input apb_addr_t addr, input apb_word_t data, input logic exp_err);
        apb_word_t rd;
        logic      err;
        apb_transfer(1'b1, addr, data, rd, err);
        check_value({31'b0, err}, {31'b0, exp_err}, $sformatf("pslverr on write to %h", addr));
        check_value(rd, '0, $sformatf("prdata on write to %h", addr));
    endtask

    task automatic apb_read(input apb_addr_t addr, input logic exp_err, output apb_word_t data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        check_value({31'b0, err}, {31'b0, exp_err}, $sformatf("pslverr on read of %h", addr));
    endtask

    task automatic wait_done();
        apb_word_t st;
        int        polls;
        polls = 0;
        apb_read(REG_STATUS, 1'b0, st);
        while (!st[1] && polls < DONE_POLLS) begin
            apb_read(REG_STATUS, 1'b0, st);
            polls++;
        end
        if (!st[1])
            abort_run("Run did not finish, STATUS never showed done");
        else
            check_value(st, 32'h2, "STATUS after the run");
    endtask

    // Store word layout with the lower element in the low byte
    function automatic blk_t a_word(input int i);
        return {a_cur[i / KB][2 * (i % KB) + 1], a_cur[i / KB][2 * (i % KB)]};
    endfunction

    function automatic blk_t w_word(input int j);
        return {w_cur[j / KB][2 * (j % KB) + 1], w_cur[j / KB][2 * (j % KB)]};
    endfunction

    task automatic load_stores();
        for (int i = 0; i < A_WORDS; i++)
            apb_write(A_BASE + apb_addr_t'(4 * i), {16'b0, a_word(i)}, 1'b0);
        for (int j = 0; j < W_WORDS; j++)
            apb_write(W_BASE + apb_addr_t'(4 * j), {16'b0, w_word(j)}, 1'b0);
    endtask

    task automatic check_stores();
        apb_word_t rd;
        for (int i = 0; i < A_WORDS; i++) begin
            apb_read(A_BASE + apb_addr_t'(4 * i), 1'b0, rd);
            check_value(rd, {16'b0, a_word(i)}, $sformatf("input store word %0d", i));
        end
        for (int j = 0; j < W_WORDS; j++) begin
            apb_read(W_BASE + apb_addr_t'(4 * j), 1'b0, rd);
            check_value(rd, {16'b0, w_word(j)}, $sformatf("weight store word %0d", j));
        end
    endtask

    task automatic check_results();
        apb_word_t rd;
        for (int r = 0; r < ROWS_A; r++) begin
            for (int c = 0; c < COLS_W; c++) begin
                apb_read(RES_BASE + apb_addr_t'(4 * (r * COLS_W + c)), 1'b0, rd);
                check_value(rd, c_exp[r][c], $sformatf("C[%0d][%0d]", r, c));
            end
        end
    endtask

    // Signed sum over k of A[r][k] times W[k][c]
    task automatic compute_expected();
        int sum;
        for (int r = 0; r < ROWS_A; r++) begin
            for (int c = 0; c < COLS_W; c++) begin
                sum = 0;
                for (int k = 0; k < INNER; k++)
                    sum += int'(a_cur[r][k]) * int'(w_cur[c][k]);
                c_exp[r][c] = acc_t'(sum);
            end
        end
    endtask

    task automatic start_run();
        apb_word_t st;
        apb_write(REG_CTRL, 32'h1, 1'b0);
        apb_read(REG_STATUS, 1'b0, st);
        check_value(st, 32'h1, "STATUS right after start");
    endtask

    initial begin
        apb_word_t   rd;
        logic [7:0]  b;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = LFSR_SEED;

        $readmemh("tests/linproj_patterns.txt", pat_mem);
        if ($isunknown(pat_mem[11]))
            abort_run("Pattern file tests/linproj_patterns.txt could not be read");
        for (int r = 0; r < ROWS_A; r++) begin
            for (int k = 0; k < INNER; k++)
                a_cur[r][k] = pat_mem[r][8 * k +: 8];
            for (int c = 0; c < COLS_W; c++)
                c_exp[r][c] = pat_mem[8 + r][32 * c +: 32];
        end
        for (int c = 0; c < COLS_W; c++)
            for (int k = 0; k < INNER; k++)
                w_cur[c][k] = pat_mem[4 + c][8 * k +: 8];

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // Idle status and cleared results after reset
        apb_read(REG_STATUS, 1'b0, rd);
        check_value(rd, '0, "STATUS after reset");
        for (int i = 0; i < RES_WORDS; i++) begin
            apb_read(RES_BASE + apb_addr_t'(4 * i), 1'b0, rd);
            check_value(rd, '0, $sformatf("result word %0d after reset", i));
        end

        load_stores();
        check_stores();

        // First run with host traffic rejected while busy
        start_run();
        apb_write(A_BASE, 32'h0000_7f7f, 1'b1);
        apb_write(W_BASE + 12'h03c, 32'h0000_8181, 1'b1);
        apb_write(REG_CTRL, 32'h1, 1'b1);
        wait_done();
        check_results();

        // Illegal accesses once idle
        apb_write(RES_BASE, 32'h1234_5678, 1'b1);
        apb_write(REG_STATUS, 32'h3, 1'b1);
        apb_write(12'h400, 32'hffff_ffff, 1'b1);
        apb_read(12'h080, 1'b1, rd);
        check_value(rd, '0, "prdata on unmapped read");
        apb_read(12'h102, 1'b1, rd);
        check_value(rd, '0, "prdata on misaligned read");
        check_stores();
        check_results();

        // Second run on random weights
        for (int c = 0; c < COLS_W; c++) begin
            for (int k = 0; k < INNER; k++) begin
                next_rand_byte(b);
                w_cur[c][k] = elem_t'(b);
            end
        end
        load_stores();
        compute_expected();
        start_run();
        wait_done();
        check_results();
        check_stores();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/linproj_pkg.sv
src/linproj_if.sv
src/apb_front.sv
src/mat_store.sv
src/proj_seq.sv
src/block_mac.sv
src/result_buf.sv
src/linproj_top.sv
tests/tb_linproj.sv
